// ==== bench/rv_core_lite_properties.sv ====
`timescale 1ns/100ps

module rv_core_lite_properties (
    input  logic                CLK,
    input  logic                reset,
    input  logic                fetch_req,
    input  logic                fetch_valid,
    input  rv_core_pkg::addr_t  fetch_addr,
    input  rv_core_pkg::addr_t  pc,
    input  rv_core_pkg::cause_t mcause,
    input  logic                trap_taken,
    input  logic                wfi,
    input  logic                halt,
    input  logic                core_clk_en
);
    import rv_core_pkg::*;

    // *********************************************************
    // reset and fetch.
    // *********************************************************

    // outputs one edge after reset.
    reset_state: assert property (@(posedge CLK)
        reset |=> (pc == RESET_PC) && fetch_req && !wfi && !halt && !trap_taken
                  && (mcause == CAUSE_NONE) && core_clk_en)
        else $error("outputs differ from their reset values");

    // request and address held until valid.
    fetch_hold: assert property (@(posedge CLK) disable iff (reset)
        (fetch_req && !fetch_valid) |=> fetch_req && $stable(fetch_addr))
        else $error("fetch request or address moved before valid");

    // *********************************************************
    // sleep and traps.
    // *********************************************************

    // no fetch while waiting for an interrupt.
    sleep_no_fetch: assert property (@(posedge CLK) disable iff (reset)
        wfi |-> !fetch_req)
        else $error("fetch requested while wfi is high");

    // enable low only inside sleep.
    gated_in_sleep: assert property (@(posedge CLK) disable iff (reset)
        !core_clk_en |-> wfi && !fetch_req)
        else $error("core clock enable low outside sleep");

    // a halted hart takes no trap.
    halt_no_trap: assert property (@(posedge CLK) disable iff (reset)
        !(halt && trap_taken))
        else $error("halt and trap_taken high together");

endmodule

bind rv_core_lite rv_core_lite_properties i_rv_core_lite_properties (
    .CLK         (CLK),
    .reset       (reset),
    .fetch_req   (fetch_req),
    .fetch_valid (fetch_valid),
    .fetch_addr  (fetch_addr),
    .pc          (pc),
    .mcause      (mcause),
    .trap_taken  (trap_taken),
    .wfi         (wfi),
    .halt        (halt),
    .core_clk_en (core_clk_en)
);

// ==== bench/rv_core_lite_tb.sv ====
`timescale 1ns/100ps

module rv_core_lite_tb;
    import rv_core_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 8;
    localparam int NUM_TESTS       = 5;
    localparam int PROG_WORDS      = 8;
    localparam int CYCLES_PER_TEST = 200;
    // soft_int column value for no soft interrupt.
    localparam int NO_SOFT         = -1;

    logic   CLK;
    logic   reset;
    mtime_t mtime;
    logic   soft_int;
    logic   fetch_req;
    addr_t  fetch_addr;
    word_t  fetch_data;
    logic   fetch_valid;
    addr_t  pc;
    cause_t mcause;
    logic   trap_taken;
    logic   wfi;
    logic   halt;

    // *********************************************************
    // program table.
    // *********************************************************

    string  test_name  [NUM_TESTS];
    word_t  test_prog  [NUM_TESTS][PROG_WORDS];
    int     test_soft  [NUM_TESTS];
    cause_t test_cause [NUM_TESTS];
    addr_t  test_pc    [NUM_TESTS];
    logic   test_halt  [NUM_TESTS];
    logic   test_sleep [NUM_TESTS];
    int     num_loaded;

    // run state.
    string       cur_test;
    int          cur_index;
    int          cycle_count;
    int          fetch_wait;
    logic        fetch_armed;
    // mtime seen at the last rising edge.
    mtime_t      edge_mtime;
    // expected timer compare from the last timer write.
    mtime_t      timer_due;

    rv_core_lite i_rv_core_lite (
        .CLK         (CLK),
        .reset       (reset),
        .mtime       (mtime),
        .soft_int    (soft_int),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_data  (fetch_data),
        .fetch_valid (fetch_valid),
        .pc          (pc),
        .mcause      (mcause),
        .trap_taken  (trap_taken),
        .wfi         (wfi),
        .halt        (halt)
    );

    initial begin
        CLK = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            CLK = ~CLK;
        end
    end

    // bound on the whole run.
    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

    // *********************************************************
    // reporting and compares.
    // *********************************************************

    task automatic report_failure(string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_addr(string field, addr_t expected, addr_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("CHECK FAILED %s %s: expected %h, actual %h",
                                     cur_test, field, expected, actual));
        end
    endtask

    task automatic check_cause(string field, cause_t expected, cause_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("CHECK FAILED %s %s: expected %0d, actual %0d",
                                     cur_test, field, expected, actual));
        end
    endtask

    task automatic check_bit(string field, logic expected, logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("CHECK FAILED %s %s: expected %b, actual %b",
                                     cur_test, field, expected, actual));
        end
    endtask

    // *********************************************************
    // instruction memory model.
    // *********************************************************

    // opcode in the top nibble, imm below.
    function automatic word_t make_instr(opcode_t op, imm_t imm);
        return {op, imm};
    endfunction

    // nop whose imm folds in every address bit.
    function automatic word_t fill_word(addr_t addr);
        imm_t tag;
        tag = addr[27:0] ^ {24'd0, addr[31:28]};
        return {OP_NOP, tag};
    endfunction

    function automatic word_t read_imem(addr_t addr);
        addr_t offset;
        offset = addr - RESET_PC;
        if ((offset < addr_t'(PROG_WORDS * 4)) && (offset[1:0] == 2'b00)) begin
            return test_prog[cur_index][offset[4:2]];
        end
        return fill_word(addr);
    endfunction

    // answers a request after 0 to 3 cycles.
    task automatic serve_fetch();
        word_t w;
        if (reset || fetch_valid) begin
            // a valid here completed on the last edge.
            fetch_valid = 1'b0;
            fetch_armed = 1'b0;
        end else if (fetch_req) begin
            if (!fetch_armed) begin
                fetch_armed = 1'b1;
                fetch_wait  = int'($urandom_range(3, 0));
            end
            if (fetch_wait == 0) begin
                w           = read_imem(fetch_addr);
                fetch_data  = w;
                fetch_valid = 1'b1;
                // compare as the timer write will leave it.
                case (w[31:28])
                    OP_SET_TIMER: timer_due = mtime + mtime_t'(w[27:0]);
                    OP_CLR_TIMER: timer_due = TIMER_OFF;
                    default: ;
                endcase
            end else begin
                fetch_wait = fetch_wait - 1;
            end
        end
    endtask

    // one cycle of stimulus on the falling edge.
    task automatic step_cycle();
        @(negedge CLK);
        edge_mtime = mtime;
        mtime      = mtime + 64'd1;
        if (!reset) begin
            cycle_count = cycle_count + 1;
            if ((test_soft[cur_index] != NO_SOFT) && (cycle_count >= test_soft[cur_index])) begin
                soft_int = 1'b1;
            end
        end
        serve_fetch();
    endtask

    // *********************************************************
    // test sequence.
    // *********************************************************

    task automatic add_test(string name, word_t w0, word_t w1, word_t w2, word_t w3,
                            word_t w4, int soft_at, cause_t cause, addr_t final_pc,
                            logic exp_halt, logic exp_sleep);
        int i;
        for (i = 0; i < PROG_WORDS; i++) begin
            test_prog[num_loaded][i] = fill_word(RESET_PC + addr_t'(i * 4));
        end
        test_prog[num_loaded][0] = w0;
        test_prog[num_loaded][1] = w1;
        test_prog[num_loaded][2] = w2;
        test_prog[num_loaded][3] = w3;
        test_prog[num_loaded][4] = w4;
        test_name[num_loaded]    = name;
        test_soft[num_loaded]    = soft_at;
        test_cause[num_loaded]   = cause;
        test_pc[num_loaded]      = final_pc;
        test_halt[num_loaded]    = exp_halt;
        test_sleep[num_loaded]   = exp_sleep;
        num_loaded               = num_loaded + 1;
    endtask

    task automatic apply_reset();
        reset       = 1'b1;
        soft_int    = 1'b0;
        fetch_valid = 1'b0;
        cycle_count = 0;
        timer_due   = TIMER_OFF;
        repeat (RESET_CYCLES) step_cycle();
        reset = 1'b0;
    endtask

    task automatic run_test(int t);
        addr_t sleep_pc;
        logic  saw_wfi;
        cur_index = t;
        cur_test  = test_name[t];
        apply_reset();
        check_bit("fetch_req after reset", 1'b1, fetch_req);
        check_addr("fetch_addr after reset", RESET_PC, fetch_addr);
        check_bit("wfi after reset", 1'b0, wfi);
        check_bit("halt after reset", 1'b0, halt);
        check_cause("mcause after reset", CAUSE_NONE, mcause);
        saw_wfi  = 1'b0;
        sleep_pc = RESET_PC;
        do begin
            step_cycle();
            if (wfi && !saw_wfi) begin
                saw_wfi  = 1'b1;
                sleep_pc = pc;
            end else if (wfi) begin
                // hart frozen while asleep.
                check_addr("pc during sleep", sleep_pc, pc);
                check_bit("fetch_req during sleep", 1'b0, fetch_req);
            end
        end while (!halt && !trap_taken);
        check_bit("halt", test_halt[t], halt);
        check_bit("trap_taken", !test_halt[t], trap_taken);
        check_addr("final pc", test_pc[t], pc);
        check_cause("mcause", test_cause[t], mcause);
        check_bit("wfi seen", test_sleep[t], saw_wfi);
        if (test_cause[t] == CAUSE_TIMER) begin
            check_bit("trap after compare", 1'b1, edge_mtime >= timer_due);
        end
    endtask

    initial begin
        int t;
        reset       = 1'b1;
        soft_int    = 1'b0;
        mtime       = '0;
        fetch_data  = '0;
        fetch_valid = 1'b0;
        fetch_armed = 1'b0;
        fetch_wait  = 0;
        cur_index   = 0;
        cycle_count = 0;
        edge_mtime  = '0;
        timer_due   = TIMER_OFF;
        num_loaded  = 0;
        void'($urandom(54568));

        // name, five words, soft cycle, cause, final pc, halt, sleep.
        add_test("straight_nops", make_instr(OP_NOP, 28'd0), make_instr(OP_NOP, 28'd0),
                 make_instr(4'hA, 28'h123), make_instr(OP_NOP, 28'd0),
                 make_instr(OP_HALT, 28'd0), NO_SOFT, CAUSE_NONE, RESET_PC + 32'd16,
                 1'b1, 1'b0);
        add_test("timer_wake", make_instr(OP_SET_TIMER, 28'd30), make_instr(OP_SET_MIE, 28'd2),
                 make_instr(OP_WFI, 28'd0), make_instr(OP_HALT, 28'd0),
                 make_instr(OP_HALT, 28'd0), NO_SOFT, CAUSE_TIMER, TRAP_VECTOR, 1'b0, 1'b1);
        // soft and timer both pending.
        add_test("soft_priority", make_instr(OP_SET_TIMER, 28'd1), make_instr(OP_SET_MIE, 28'd3),
                 make_instr(OP_WFI, 28'd0), make_instr(OP_HALT, 28'd0),
                 make_instr(OP_HALT, 28'd0), 1, CAUSE_SOFT, TRAP_VECTOR, 1'b0, 1'b0);
        // soft raised in sleep but masked.
        add_test("masked_soft", make_instr(OP_SET_TIMER, 28'd60), make_instr(OP_SET_MIE, 28'd2),
                 make_instr(OP_WFI, 28'd0), make_instr(OP_HALT, 28'd0),
                 make_instr(OP_HALT, 28'd0), 25, CAUSE_TIMER, TRAP_VECTOR, 1'b0, 1'b1);
        add_test("timer_off_soft", make_instr(OP_SET_TIMER, 28'd1),
                 make_instr(OP_CLR_TIMER, 28'd0), make_instr(OP_SET_MIE, 28'd3),
                 make_instr(OP_WFI, 28'd0), make_instr(OP_HALT, 28'd0), 40, CAUSE_SOFT,
                 TRAP_VECTOR, 1'b0, 1'b1);

        for (t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rv_core_lite testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module rv_core_lite_tb \
    -Mdir obj_dir \
    -f rv_core_lite.f

./obj_dir/Vrv_core_lite_tb

// ==== rv_core_lite.f ====
verilog/rv_core_pkg.sv
verilog/core_clk_gating.sv
verilog/interrupt_unit.sv
verilog/hart_sequencer.sv
verilog/rv_core_lite.sv
bench/rv_core_lite_properties.sv
bench/rv_core_lite_tb.sv

// ==== verilog/core_clk_gating.sv ====
`timescale 1ns/100ps

module core_clk_gating (
    input  logic CLK,
    input  logic reset,
    input  logic wfi,
    input  logic irq_pending,
    output logic core_clk_en
);

    // *********************************************************
    // sleep and wake conditions.
    // *********************************************************

    logic sleep_cond;
    logic wake_cond;

    // go to sleep only with nothing pending.
    // a wfi that meets a pending interrupt never gates the core.
    assign sleep_cond = core_clk_en && wfi && !irq_pending;

    // any enabled pending interrupt wakes the core.
    assign wake_cond = !core_clk_en && irq_pending;

    // *********************************************************
    // enable register.
    // *********************************************************

    always_ff @(posedge CLK) begin
        if (reset) begin
            // core runs out of reset.
            core_clk_en <= 1'b1;
        end else if (sleep_cond) begin
            core_clk_en <= 1'b0;
        end else if (wake_cond) begin
            // one edge after pending rises.
            core_clk_en <= 1'b1;
        end
    end

endmodule

// ==== verilog/hart_sequencer.sv ====
`timescale 1ns/100ps

module hart_sequencer (
    input  logic                 CLK,
    input  logic                 reset,
    input  logic                 core_clk_en,
    output logic                 fetch_req,
    output rv_core_pkg::addr_t   fetch_addr,
    input  rv_core_pkg::word_t   fetch_data,
    input  logic                 fetch_valid,
    input  logic                 irq_pending,
    input  rv_core_pkg::cause_t  irq_cause,
    output rv_core_pkg::opcode_t csr_op,
    output rv_core_pkg::imm_t    csr_imm,
    output logic                 csr_we,
    output logic                 trap_taken,
    output rv_core_pkg::addr_t   pc,
    output rv_core_pkg::cause_t  mcause,
    output logic                 wfi,
    output logic                 halt
);
    import rv_core_pkg::*;

    seq_state_t state;
    // decoded fields of the fetched word.
    opcode_t    opcode;
    imm_t       imm;
    // a fetch completes this cycle.
    logic       fetch_done;
    // opcode goes to the interrupt unit.
    logic       csr_class;

    // *********************************************************
    // decode.
    // *********************************************************

    assign opcode = fetch_data[31:28];
    assign imm    = fetch_data[27:0];

    // fetch is only ever outstanding in ST_FETCH.
    assign fetch_done = core_clk_en && (state == ST_FETCH) && fetch_req && fetch_valid;

    always_comb begin
        case (opcode)
            OP_SET_TIMER,
            OP_SET_MIE,
            OP_CLR_TIMER: csr_class = 1'b1;
            default:      csr_class = 1'b0;
        endcase
    end

    // csr write lands on the execute edge.
    assign csr_op  = opcode;
    assign csr_imm = imm;
    assign csr_we  = fetch_done && csr_class;

    // fetch address is always the current pc.
    // pc holds while a fetch is outstanding.
    assign fetch_addr = pc;

    // *********************************************************
    // control FSM.
    // *********************************************************

    always_ff @(posedge CLK) begin
        if (reset) begin
            state      <= ST_FETCH;
            pc         <= RESET_PC;
            fetch_req  <= 1'b1;
            wfi        <= 1'b0;
            halt       <= 1'b0;
            trap_taken <= 1'b0;
            mcause     <= CAUSE_NONE;
        end else begin
            // single cycle pulse.
            trap_taken <= 1'b0;

            if (core_clk_en) begin
                case (state)
                    ST_FETCH: begin
                        if (fetch_done) begin
                            // execute, then one idle cycle for trap check.
                            fetch_req <= 1'b0;
                            case (opcode)
                                OP_HALT: begin
                                    // pc stays on the halt.
                                    state <= ST_HALTED;
                                    halt  <= 1'b1;
                                end
                                OP_WFI: begin
                                    pc    <= pc + 32'd4;
                                    state <= ST_SLEEP;
                                    wfi   <= 1'b1;
                                end
                                // nop, csr ops and unknown opcodes.
                                default: pc <= pc + 32'd4;
                            endcase
                        end else if (!fetch_req) begin
                            // between fetches. traps only here.
                            fetch_req <= 1'b1;
                            if (irq_pending) begin
                                pc         <= TRAP_VECTOR;
                                mcause     <= irq_cause;
                                trap_taken <= 1'b1;
                            end
                        end
                    end

                    ST_SLEEP: begin
                        // leave once enabled and something is pending.
                        // trap follows in the next cycle.
                        if (irq_pending) begin
                            state <= ST_FETCH;
                            wfi   <= 1'b0;
                        end
                    end

                    // held until reset.
                    ST_HALTED: state <= ST_HALTED;

                    default: state <= ST_FETCH;
                endcase
            end
        end
    end

endmodule

// ==== verilog/interrupt_unit.sv ====
`timescale 1ns/100ps

module interrupt_unit (
    input  logic                 CLK,
    input  logic                 reset,
    input  rv_core_pkg::mtime_t  mtime,
    input  logic                 soft_int,
    input  rv_core_pkg::opcode_t csr_op,
    input  rv_core_pkg::imm_t    csr_imm,
    input  logic                 csr_we,
    input  logic                 trap_taken,
    output logic                 irq_pending,
    output rv_core_pkg::cause_t  irq_cause
);
    import rv_core_pkg::*;

    // machine timer compare.
    mtime_t mtimecmp;
    // machine interrupt enables.
    mie_t   mie;
    // raw pending bits.
    mie_t   mip;
    // pending and enabled.
    mie_t   irq_active;

    // *********************************************************
    // timer compare register.
    // *********************************************************

    always_ff @(posedge CLK) begin
        if (reset) begin
            mtimecmp <= TIMER_OFF;
        end else if (csr_we) begin
            case (csr_op)
                // relative to the current time, imm zero extended.
                OP_SET_TIMER: mtimecmp <= mtime + mtime_t'(csr_imm);
                OP_CLR_TIMER: mtimecmp <= TIMER_OFF;
                default:      mtimecmp <= mtimecmp;
            endcase
        end
    end

    // *********************************************************
    // interrupt enable register.
    // *********************************************************

    always_ff @(posedge CLK) begin
        if (reset) begin
            mie <= '0;
        end else if (csr_we && (csr_op == OP_SET_MIE)) begin
            // an explicit write beats the trap clear.
            mie <= csr_imm[1:0];
        end else if (trap_taken) begin
            // trap runs with interrupts off.
            mie <= '0;
        end
    end

    // *********************************************************
    // pending bits and cause.
    // *********************************************************

    // software interrupt is a plain level.
    assign mip[MIE_SOFT_BIT] = soft_int;

    // timer fires once time reaches the compare.
    // the all ones compare value never fires.
    assign mip[MIE_TIMER_BIT] = (mtimecmp != TIMER_OFF) && (mtime >= mtimecmp);

    assign irq_active  = mip & mie;
    assign irq_pending = |irq_active;

    // soft has priority over timer.
    always_comb begin
        if (irq_active[MIE_SOFT_BIT]) begin
            irq_cause = CAUSE_SOFT;
        end else if (irq_active[MIE_TIMER_BIT]) begin
            irq_cause = CAUSE_TIMER;
        end else begin
            irq_cause = CAUSE_NONE;
        end
    end

endmodule

// ==== verilog/rv_core_lite.sv ====
`timescale 1ns/100ps

module rv_core_lite (
    input  logic                CLK,
    input  logic                reset,
    input  rv_core_pkg::mtime_t mtime,
    input  logic                soft_int,
    output logic                fetch_req,
    output rv_core_pkg::addr_t  fetch_addr,
    input  rv_core_pkg::word_t  fetch_data,
    input  logic                fetch_valid,
    output rv_core_pkg::addr_t  pc,
    output rv_core_pkg::cause_t mcause,
    output logic                trap_taken,
    output logic                wfi,
    output logic                halt
);
    import rv_core_pkg::*;

    // clock enable for the sequencer.
    logic    core_clk_en;

    // interrupt unit to sequencer.
    logic    irq_pending;
    cause_t  irq_cause;

    // sequencer to interrupt unit.
    opcode_t csr_op;
    imm_t    csr_imm;
    logic    csr_we;

    // *********************************************************
    // blocks.
    // *********************************************************

    // sleeps on wfi, wakes on pending.
    core_clk_gating i_core_clk_gating (
        .CLK         (CLK),
        .reset       (reset),
        .wfi         (wfi),
        .irq_pending (irq_pending),
        .core_clk_en (core_clk_en)
    );

    // timer, enables and cause.
    interrupt_unit i_interrupt_unit (
        .CLK         (CLK),
        .reset       (reset),
        .mtime       (mtime),
        .soft_int    (soft_int),
        .csr_op      (csr_op),
        .csr_imm     (csr_imm),
        .csr_we      (csr_we),
        .trap_taken  (trap_taken),
        .irq_pending (irq_pending),
        .irq_cause   (irq_cause)
    );

    // free running clock, qualified by the enable.
    hart_sequencer i_hart_sequencer (
        .CLK         (CLK),
        .reset       (reset),
        .core_clk_en (core_clk_en),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_data  (fetch_data),
        .fetch_valid (fetch_valid),
        .irq_pending (irq_pending),
        .irq_cause   (irq_cause),
        .csr_op      (csr_op),
        .csr_imm     (csr_imm),
        .csr_we      (csr_we),
        .trap_taken  (trap_taken),
        .pc          (pc),
        .mcause      (mcause),
        .wfi         (wfi),
        .halt        (halt)
    );

endmodule

// ==== verilog/rv_core_pkg.sv ====
package rv_core_pkg;

    // *********************************************************
    // widths with a meaning.
    // *********************************************************

    // instruction word.
    typedef logic [31:0] word_t;
    // pc and fetch address.
    typedef logic [31:0] addr_t;
    // machine time and timer compare.
    typedef logic [63:0] mtime_t;
    // top nibble of an instruction.
    typedef logic [3:0]  opcode_t;
    // low 28 bits of an instruction.
    typedef logic [27:0] imm_t;
    // machine interrupt cause code.
    typedef logic [3:0]  cause_t;
    // bit 0 soft enable, bit 1 timer enable.
    typedef logic [1:0]  mie_t;

    // sequencer states.
    typedef enum logic [1:0] {ST_FETCH, ST_SLEEP, ST_HALTED} seq_state_t;

    // *********************************************************
    // constants.
    // *********************************************************

    localparam addr_t   RESET_PC     = 32'h8000_0000;
    localparam addr_t   TRAP_VECTOR  = 32'h8000_0100;

    // reduced control instruction set.
    localparam opcode_t OP_NOP       = 4'd0;
    localparam opcode_t OP_SET_TIMER = 4'd1;
    localparam opcode_t OP_SET_MIE   = 4'd2;
    localparam opcode_t OP_CLR_TIMER = 4'd3;
    localparam opcode_t OP_WFI       = 4'd4;
    localparam opcode_t OP_HALT      = 4'd5;

    // machine interrupt numbering.
    localparam cause_t  CAUSE_NONE   = 4'd0;
    localparam cause_t  CAUSE_SOFT   = 4'd3;
    localparam cause_t  CAUSE_TIMER  = 4'd7;

    // bit positions inside mie and mip.
    localparam int      MIE_SOFT_BIT  = 0;
    localparam int      MIE_TIMER_BIT = 1;

    // compare value that disables the timer.
    localparam mtime_t  TIMER_OFF    = 64'hFFFF_FFFF_FFFF_FFFF;

endpackage
